// File: include/fetch_params.svh
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// cache geometry, 16 lines of 16 words (64 bytes)
`define ICACHE_LINES 16
`define ICACHE_WORDS 16

// field widths of the fetch address
`define ICACHE_IDX_W  4
`define ICACHE_WORD_W 4
`define ICACHE_TAG_W  22

// low bit of each field
// word select starts at bit 2, bytes within a word are never addressed
`define ICACHE_IDX_LSB 6
`define ICACHE_TAG_LSB 10

// first fetch address after reset
`define FETCH_RESET_PC 32'h0000_0100

`endif

// File: rtl/fetch_pkg.sv
`include "fetch_params.svh"

package fetch_pkg;

	// ==================================================
	// pipeline payloads
	// ==================================================

	// request from the issue stage into the cache
	typedef struct packed {
		logic [31:0] addr;
		logic        valid;
	} fetch_req_t;

	// fetched instruction tagged with its address
	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] instr;
	} fetch_word_t;

	// ==================================================
	// refill path
	// ==================================================

	// one data beat into the arrays, commit also writes tag and valid
	typedef struct packed {
		logic [`ICACHE_IDX_W-1:0]  idx;
		logic [`ICACHE_WORD_W-1:0] word;
		logic [31:0]               data;
		logic                      we;
		logic                      commit;
		logic [`ICACHE_TAG_W-1:0]  tag;
	} line_write_t;

	// refill sequencer states
	typedef enum logic [1:0] {
		FILL_IDLE,
		FILL_BUSY,
		FILL_DONE
	} fill_state_t;

endpackage

// File: rtl/fetch_pc.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_pc import fetch_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        redirect,
	input  logic [31:0] redirect_addr,
	input  logic        hold,
	input  logic        rd_wait,
	output fetch_req_t  req
);

	logic [31:0] pc;
	logic        pc_valid;
	logic        advance;

	// the current word has been accepted by the cache and the decoder
	assign advance = pc_valid && !rd_wait && !hold;

	// redirect wins over hold, hold wins over everything else
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			pc       <= `FETCH_RESET_PC;
			pc_valid <= 1'b0;
		end else if (redirect) begin
			pc       <= redirect_addr;
			// one bubble so the new target starts a clean request
			pc_valid <= 1'b0;
		end else if (!pc_valid) begin
			pc_valid <= 1'b1;
		end else if (advance) begin
			pc <= pc + 32'd4;
		end
	end

	always_comb begin
		req.addr  = pc;
		req.valid = pc_valid;
	end

endmodule

// File: rtl/icache.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module icache import fetch_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  fetch_req_t  req,
	input  line_write_t fill_wr,
	output logic        hit,
	output logic        rd_wait,
	output fetch_word_t rd_word
);

	// ==================================================
	// storage
	// ==================================================

	logic [`ICACHE_LINES-1:0]  line_valid;
	logic [`ICACHE_TAG_W-1:0]  tag_mem  [`ICACHE_LINES];
	logic [31:0]               data_mem [`ICACHE_LINES][`ICACHE_WORDS];

	// ==================================================
	// request address fields
	// ==================================================

	logic [`ICACHE_TAG_W-1:0]  rd_tag;
	logic [`ICACHE_IDX_W-1:0]  rd_idx;
	logic [`ICACHE_WORD_W-1:0] rd_word_sel;

	assign rd_tag      = req.addr[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];
	assign rd_idx      = req.addr[`ICACHE_IDX_LSB +: `ICACHE_IDX_W];
	assign rd_word_sel = req.addr[2 +: `ICACHE_WORD_W];

	// ==================================================
	// lookup
	// ==================================================

	// hit is answered in the same cycle as the request
	assign hit     = line_valid[rd_idx] && (tag_mem[rd_idx] == rd_tag);
	assign rd_wait = req.valid && !hit;

	always_comb begin
		rd_word.addr  = req.addr;
		rd_word.instr = data_mem[rd_idx][rd_word_sel];
	end

	// ==================================================
	// line write port
	// ==================================================

	// data and tag arrays
	always_ff @(posedge clk) begin
		if (fill_wr.we)
			data_mem[fill_wr.idx][fill_wr.word] <= fill_wr.data;
		if (fill_wr.commit)
			tag_mem[fill_wr.idx] <= fill_wr.tag;
	end

	// valid is dropped on the first beat into a line and set with the tag,
	// so a fill that is abandoned leaves the line invalid
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			line_valid <= '0;
		else if (fill_wr.commit)
			line_valid[fill_wr.idx] <= 1'b1;
		else if (fill_wr.we)
			line_valid[fill_wr.idx] <= 1'b0;
	end

endmodule

// File: rtl/icache_fill.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module icache_fill import fetch_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  fetch_req_t  req,
	input  logic        hit,
	input  logic        hold,
	input  logic        bus_ack,
	input  logic        bus_ready,
	input  logic [31:0] bus_rdata,
	output line_write_t fill_wr,
	output logic        bus_req,
	output logic        bus_rd,
	output logic [31:0] bus_addr
);

	localparam int LINE_W = 32 - `ICACHE_IDX_LSB;

	fill_state_t               state;
	logic [`ICACHE_WORD_W-1:0] beat;
	logic [LINE_W-1:0]         prev_line;
	logic [LINE_W-1:0]         cur_line;
	logic                      miss;
	logic                      abort;
	logic                      take;
	logic                      last_beat;

	assign cur_line  = req.addr[31:`ICACHE_IDX_LSB];
	assign miss      = req.valid && !hit;
	assign last_beat = (beat == '1);

	// fetch stream left the line being filled, or was redirected
	assign abort = (state == FILL_BUSY) && (!req.valid || hit || (cur_line != prev_line));

	// ==================================================
	// bus side
	// ==================================================

	assign bus_req  = miss;
	// hold parks the fill without losing its position
	assign bus_rd   = miss && bus_ack && !hold && !abort && (state != FILL_DONE);
	assign bus_addr = bus_rd ? {cur_line, beat, 2'b00} : 32'h0;
	assign take     = bus_rd && bus_ready;

	// every accepted beat becomes one data write
	always_comb begin
		fill_wr.idx    = req.addr[`ICACHE_IDX_LSB +: `ICACHE_IDX_W];
		fill_wr.word   = beat;
		fill_wr.data   = bus_rdata;
		fill_wr.we     = take;
		fill_wr.commit = take && last_beat;
		fill_wr.tag    = req.addr[`ICACHE_TAG_LSB +: `ICACHE_TAG_W];
	end

	// ==================================================
	// sequencer
	// ==================================================

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= FILL_IDLE;
			beat      <= '0;
			prev_line <= '0;
		end else begin
			prev_line <= cur_line;
			case (state)
				FILL_IDLE: begin
					if (take) begin
						beat  <= beat + 1'b1;
						state <= FILL_BUSY;
					end
				end
				FILL_BUSY: begin
					if (abort) begin
						beat  <= '0;
						state <= FILL_IDLE;
					end else if (take) begin
						// counter wraps to zero on the last beat
						beat <= beat + 1'b1;
						if (last_beat)
							state <= FILL_DONE;
					end
				end
				// line hits this cycle, nothing to fetch
				default: state <= FILL_IDLE;
			endcase
		end
	end

endmodule

// File: rtl/fetch_deliver.sv
`timescale 1ns/1ps

module fetch_deliver import fetch_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  fetch_word_t rd_word,
	input  logic        rd_wait,
	input  logic        req_valid,
	input  logic        redirect,
	input  logic        hold,
	output fetch_word_t out_word,
	output logic        out_valid
);

	logic capture;

	// a word is ready and the decoder can take it
	assign capture = req_valid && !rd_wait && !hold;

	// payload register
	always_ff @(posedge clk) begin
		if (capture)
			out_word <= rd_word;
	end

	// redirect squashes the old path, hold freezes the stage
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			out_valid <= 1'b0;
		else if (redirect)
			out_valid <= 1'b0;
		else if (!hold)
			out_valid <= capture;
	end

endmodule

// File: rtl/fetch_top.sv
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        redirect,
	input  logic [31:0] redirect_addr,
	input  logic        hold,
	input  logic        bus_ack,
	input  logic        bus_ready,
	input  logic [31:0] bus_rdata,
	output fetch_word_t out_word,
	output logic        out_valid,
	output logic        bus_req,
	output logic        bus_rd,
	output logic [31:0] bus_addr
);

	fetch_req_t  req;
	fetch_word_t rd_word;
	line_write_t fill_wr;
	logic        hit;
	logic        rd_wait;

	// ==================================================
	// issue
	// ==================================================

	fetch_pc u_pc (
		.clk           (clk),
		.rst_n         (rst_n),
		.redirect      (redirect),
		.redirect_addr (redirect_addr),
		.hold          (hold),
		.rd_wait       (rd_wait),
		.req           (req)
	);

	// ==================================================
	// lookup and refill
	// ==================================================

	icache u_icache (
		.clk     (clk),
		.rst_n   (rst_n),
		.req     (req),
		.fill_wr (fill_wr),
		.hit     (hit),
		.rd_wait (rd_wait),
		.rd_word (rd_word)
	);

	icache_fill u_fill (
		.clk       (clk),
		.rst_n     (rst_n),
		.req       (req),
		.hit       (hit),
		.hold      (hold),
		.bus_ack   (bus_ack),
		.bus_ready (bus_ready),
		.bus_rdata (bus_rdata),
		.fill_wr   (fill_wr),
		.bus_req   (bus_req),
		.bus_rd    (bus_rd),
		.bus_addr  (bus_addr)
	);

	// ==================================================
	// delivery
	// ==================================================

	fetch_deliver u_deliver (
		.clk       (clk),
		.rst_n     (rst_n),
		.rd_word   (rd_word),
		.rd_wait   (rd_wait),
		.req_valid (req.valid),
		.redirect  (redirect),
		.hold      (hold),
		.out_word  (out_word),
		.out_valid (out_valid)
	);

endmodule

// File: verification/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
	output logic clk
);

	// 20 ns period
	localparam int HALF_PERIOD = 10;

	initial begin
		clk = 1'b0;
		forever #(HALF_PERIOD) clk = ~clk;
	end

endmodule

// File: verification/fetch_tb.sv
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_tb import fetch_pkg::*; ();

	localparam logic [31:0] SEED            = 32'h9357d372;
	localparam int          RESET_CYCLES    = 10;
	localparam int          SEQ_WORDS       = 80;
	localparam int          HIT_WORDS       = 16;
	localparam int          ABORT_WORDS     = 9;
	localparam int          CONFLICT_RUNS   = 3;
	localparam int          RAND_WORDS      = 300;
	localparam int          CYCLES_PER_WORD = 40;
	localparam int          TOTAL_WORDS     = SEQ_WORDS + HIT_WORDS + ABORT_WORDS
		+ CONFLICT_RUNS * 8 + RAND_WORDS;

	// line 5 is filled during the sequential run
	localparam logic [31:0] HIT_ADDR   = 32'h0000_0140;
	localparam logic [31:0] ABORT_ADDR = 32'h0000_3000;
	// same index with different tags
	localparam logic [31:0] CONFLICT_A = 32'h0000_2000;
	localparam logic [31:0] CONFLICT_B = 32'h0000_2400;

	logic        clk;
	logic        rst_n;
	logic        redirect;
	logic [31:0] redirect_addr;
	logic        hold;
	logic        bus_ack;
	logic        bus_ready;
	logic [31:0] bus_rdata;
	fetch_word_t out_word;
	logic        out_valid;
	logic        bus_req;
	logic        bus_rd;
	logic [31:0] bus_addr;

	// reference model state
	logic [31:0] rng;
	logic [31:0] expected;
	logic [3:0]  beat_exp;
	int          delivered;
	int          take_count;
	logic        seen_valid;
	logic        seen_req;
	fetch_word_t seen_word;
	logic        last_valid;
	fetch_word_t last_word;
	logic        hold_prev;
	logic        redir_prev;

	tb_clock u_clock (
		.clk (clk)
	);

	fetch_top uut (
		.clk           (clk),
		.rst_n         (rst_n),
		.redirect      (redirect),
		.redirect_addr (redirect_addr),
		.hold          (hold),
		.bus_ack       (bus_ack),
		.bus_ready     (bus_ready),
		.bus_rdata     (bus_rdata),
		.out_word      (out_word),
		.out_valid     (out_valid),
		.bus_req       (bus_req),
		.bus_rd        (bus_rd),
		.bus_addr      (bus_addr)
	);

	// ==================================================
	// helpers
	// ==================================================

	function automatic logic [31:0] lcg_next(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	// memory contents where every address bit feeds the word
	function automatic logic [31:0] mem_word(input logic [31:0] addr);
		return ((addr ^ 32'h5a5a_c3e1) * 32'h0001_0dcd) + {addr[15:0], addr[31:16]};
	endfunction

	task automatic check_value(input string name, input logic [63:0] exp_val,
		input logic [63:0] act_val);
		if (act_val !== exp_val) begin
			$display("Fail %s: expected %h, actual %h", name, exp_val, act_val);
			$display("TESTS FAILED");
			$fatal(1, "stopping at the first mismatch");
		end
	endtask

	// one clock of sampling, driving, answering the bus and updating the model
	task automatic run_cycle(input logic h, input logic r, input logic [31:0] target);
		logic rdy;
		@(negedge clk);
		seen_valid = out_valid;
		seen_word  = out_word;
		seen_req   = bus_req;
		if (hold_prev && !redir_prev) begin
			check_value("hold out_valid", 64'(last_valid), 64'(seen_valid));
			if (last_valid)
				check_value("hold out_word", 64'(last_word), 64'(seen_word));
		end
		rng = lcg_next(rng);
		rdy = (rng[31:30] != 2'b00);
		hold          = h;
		redirect      = r;
		redirect_addr = r ? target : 32'h0;
		bus_ack       = bus_req;
		bus_ready     = rdy;
		#1;
		bus_rdata = mem_word(bus_addr);
		// every request is granted and a held decoder stops new beats
		check_value("bus_rd", 64'(bus_ack && !h), 64'(bus_rd));
		// the decoder takes a presented word unless it holds
		if (seen_valid && !h) begin
			check_value("word addr", 64'(expected), 64'(seen_word.addr));
			check_value("word instr", 64'(mem_word(expected)), 64'(seen_word.instr));
			expected  = expected + 32'd4;
			delivered = delivered + 1;
		end
		if (bus_rd && bus_ready) begin
			check_value("fill line", 64'({expected[31:6], 6'b0}), 64'({bus_addr[31:6], 6'b0}));
			check_value("fill beat", 64'(beat_exp), 64'(bus_addr[5:2]));
			beat_exp   = beat_exp + 4'd1;
			take_count = take_count + 1;
		end
		if (r) begin
			expected = target;
			beat_exp = 4'd0;
		end
		hold_prev  = h;
		redir_prev = r;
		last_valid = seen_valid;
		last_word  = seen_word;
	endtask

	task automatic run_words(input int count);
		int goal;
		goal = delivered + count;
		while (delivered < goal)
			run_cycle(1'b0, 1'b0, 32'h0);
	endtask

	task automatic jump_to(input logic [31:0] target);
		run_cycle(1'b0, 1'b1, target);
		take_count = 0;
	endtask

	// a cold line must be fetched in full before its first word arrives
	task automatic refill_from(input string name, input logic [31:0] target);
		jump_to(target);
		run_words(1);
		check_value(name, 64'(`ICACHE_WORDS), 64'(take_count));
	endtask

	// ==================================================
	// test sequence
	// ==================================================

	initial begin
		int   goal;
		int   i;
		logic rand_hold;
		logic rand_redirect;

		rst_n         = 1'b0;
		redirect      = 1'b0;
		redirect_addr = 32'h0;
		hold          = 1'b0;
		bus_ack       = 1'b0;
		bus_ready     = 1'b0;
		bus_rdata     = 32'h0;
		rng           = SEED;
		expected      = `FETCH_RESET_PC;
		beat_exp      = 4'd0;
		delivered     = 0;
		take_count    = 0;
		seen_valid    = 1'b0;
		seen_req      = 1'b0;
		seen_word     = '0;
		last_valid    = 1'b0;
		last_word     = '0;
		hold_prev     = 1'b0;
		redir_prev    = 1'b0;

		repeat (RESET_CYCLES) @(negedge clk);
		check_value("reset out_valid", 64'(1'b0), 64'(out_valid));
		check_value("reset bus_req", 64'(1'b0), 64'(bus_req));
		check_value("reset bus_rd", 64'(1'b0), 64'(bus_rd));
		rst_n = 1'b1;

		// straight line fetch from the reset pc across several lines
		run_words(SEQ_WORDS);

		// back into a filled line with no bus traffic expected
		jump_to(HIT_ADDR);
		goal = delivered + HIT_WORDS;
		while (delivered < goal) begin
			run_cycle(1'b0, 1'b0, 32'h0);
			check_value("hit_after_fill bus_req", 64'(1'b0), 64'(seen_req));
		end
		check_value("hit_after_fill beats", 64'(0), 64'(take_count));

		// redirect in the middle of a fill so the partial line refills from beat 0
		jump_to(ABORT_ADDR);
		while (take_count < 6)
			run_cycle(1'b0, 1'b0, 32'h0);
		refill_from("abort refill beats", ABORT_ADDR);
		run_words(ABORT_WORDS - 1);

		// two tags fighting over one index
		for (i = 0; i < CONFLICT_RUNS; i++) begin
			refill_from("conflict refill a", CONFLICT_A);
			run_words(3);
			refill_from("conflict refill b", CONFLICT_B);
			run_words(3);
		end

		// random redirects and hold
		goal = delivered + RAND_WORDS;
		while (delivered < goal) begin
			rng           = lcg_next(rng);
			rand_hold     = (rng[31:29] == 3'd0);
			rand_redirect = !rand_hold && (rng[28:24] == 5'd0);
			run_cycle(rand_hold, rand_redirect, {18'h0, rng[13:2], 2'b00});
		end

		$display("TESTS PASSED");
		$finish;
	end

	// watchdog
	initial begin
		repeat (RESET_CYCLES + TOTAL_WORDS * CYCLES_PER_WORD) @(posedge clk);
		$display("watchdog expired, the fetch stream stalled");
		$display("TESTS FAILED");
		$fatal(1, "no progress before the time limit");
	end

endmodule

// File: src.f
+incdir+include
rtl/fetch_pkg.sv
rtl/fetch_pc.sv
rtl/icache.sv
rtl/icache_fill.sv
rtl/fetch_deliver.sv
rtl/fetch_top.sv
verification/tb_clock.sv
verification/fetch_tb.sv

// File: run.sh
#!/bin/sh
# build the fetch front end testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
sim_bin=fetch_sim
log_file=sim.log

verilator --binary --timing -f src.f --top-module fetch_tb --Mdir "$build_dir" -o "$sim_bin"
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"./$build_dir/$sim_bin" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "TESTS FAILED" "$log_file"; then
	echo "failure found in $log_file"
	exit 1
fi

exit 0
